// File: lsuPkg.sv
package lsuPkg;

    typedef logic [31:0] vaddrT;
    typedef logic [33:0] paddrT;
    typedef logic [21:0] ppnT;
    typedef logic [31:0] pteT;
    typedef logic [31:0] wordT;
    typedef logic [6:0]  tagT;

    typedef enum logic [2:0] {LB, LH, LW, LBU, LHU} loadOpE;

    // Atomics sit above SW, so opcode >= AMOSWAP picks them out
    typedef enum logic [3:0] {
        SB, SH, SW,
        AMOSWAP, AMOADD, AMOXOR, AMOAND, AMOOR,
        AMOMIN, AMOMAX, AMOMINU, AMOMAXU
    } storeOpE;

    typedef enum logic [1:0] {
        excNone, excMisalign, excAccessFault, excPageFault
    } aguExcE;

    typedef enum logic [1:0] {
        privUser  = 2'b00,
        privSuper = 2'b01
    } privE;

    typedef enum logic [1:0] {walkIdle, walkLevel1, walkLevel0, walkDone} walkStateE;

    typedef enum logic [1:0] {aguIdle, aguWalking, aguResult} aguStateE;

    localparam int PTE_V = 0;
    localparam int PTE_R = 1;
    localparam int PTE_W = 2;
    localparam int PTE_X = 3;
    localparam int PTE_U = 4;
    localparam int PTE_A = 6;
    localparam int PTE_D = 7;

    localparam int PAGE_BITS = 12;

    // Physical address bits from here up must be zero
    localparam int LEGAL_TOP = 31;

endpackage

// File: pteCheck.sv
module pteCheck #(
    parameter bit isStore = 1'b0
) (
    input  lsuPkg::pteT    pte,
    input  logic           isSuper,
    input  logic           walkFault,
    input  lsuPkg::vaddrT  vaddr,
    input  lsuPkg::privE   priv,
    input  logic           sum,
    input  logic           mxr,
    output lsuPkg::paddrT  paddr,
    output lsuPkg::aguExcE except
);
    import lsuPkg::*;

    ppnT  ppn;
    logic canAccess;
    logic badPerm;

    assign ppn = pte[31:10];

    always_comb begin
        if (isSuper)
            paddr = {ppn[21:10], vaddr[PAGE_BITS+9:0]};  // 4 MiB page
        else
            paddr = {ppn, vaddr[PAGE_BITS-1:0]};
    end

    // Stores need R and W, loads may read execute-only pages under mxr
    assign canAccess = isStore ? (pte[PTE_R] && pte[PTE_W])
                               : (pte[PTE_R] || (mxr && pte[PTE_X]));

    assign badPerm = walkFault || !canAccess || !pte[PTE_A]
                  || (isStore && !pte[PTE_D])
                  || (priv == privUser && !pte[PTE_U])
                  || (priv == privSuper && pte[PTE_U] && !sum)
                  || (isSuper && ppn[9:0] != '0);  // Misaligned superpage

    always_comb begin
        if (paddr[$bits(paddrT)-1:LEGAL_TOP] != '0)
            except = excAccessFault;
        else if (badPerm)
            except = excPageFault;
        else
            except = excNone;
    end

    // Walker reports either a leaf superpage or a fault, never both
    always_comb begin
        assert final ((isSuper & walkFault) !== 1'b1)
            else $error("pteCheck: superpage flagged on a faulted walk");
    end

endmodule

// File: loadAgu.sv
module loadAgu (
    input  logic           clk,
    input  logic           rst,
    input  logic           inValid,
    input  lsuPkg::loadOpE opcode,
    input  lsuPkg::wordT   base,
    input  logic [11:0]    imm,
    input  lsuPkg::tagT    tag,
    input  logic           hold,
    input  logic           vmEnable,
    input  lsuPkg::privE   priv,
    input  logic           sum,
    input  logic           mxr,
    input  logic           pwDone,
    input  lsuPkg::pteT    pwPte,
    input  logic           pwSuper,
    input  logic           pwFault,
    output logic           stall,
    output logic           outValid,
    output lsuPkg::paddrT  outAddr,
    output logic [1:0]     outSize,
    output logic           outSignExt,
    output lsuPkg::aguExcE outExcept,
    output lsuPkg::tagT    outTag,
    output logic           pwReq,
    output lsuPkg::vaddrT  pwVaddr
);
    import lsuPkg::*;

    aguStateE   state;
    vaddrT      addr;
    vaddrT      addrQ;
    logic [1:0] size;
    aguExcE     earlyExc;
    logic       accept;
    privE       privQ;
    logic       sumQ;
    logic       mxrQ;
    paddrT      chkAddr;
    aguExcE     chkExc;

    assign addr     = base + {{20{imm[11]}}, imm};
    assign stall    = (state == aguWalking) || (state == aguResult && hold);
    assign accept   = inValid && !stall;
    assign outValid = state == aguResult;
    assign pwReq    = state == aguWalking;
    assign pwVaddr  = addrQ;

    always_comb begin
        case (opcode)
            LB, LBU: size = 2'd0;
            LH, LHU: size = 2'd1;
            default: size = 2'd2;
        endcase

        // Alignment beats the range check
        if ((size == 2'd1 && addr[0]) || (size == 2'd2 && addr[1:0] != 2'b00))
            earlyExc = excMisalign;
        else if (!vmEnable && addr[$bits(vaddrT)-1:LEGAL_TOP] != '0)
            earlyExc = excAccessFault;
        else
            earlyExc = excNone;
    end

    pteCheck #(.isStore(1'b0)) check (
        .pte      (pwPte),
        .isSuper  (pwSuper),
        .walkFault(pwFault),
        .vaddr    (addrQ),
        .priv     (privQ),
        .sum      (sumQ),
        .mxr      (mxrQ),
        .paddr    (chkAddr),
        .except   (chkExc)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= aguIdle;
        end else begin
            if (state == aguResult && !hold)
                state <= aguIdle;
            if (state == aguWalking && pwDone)
                state <= aguResult;
            if (accept)
                state <= (vmEnable && earlyExc == excNone) ? aguWalking : aguResult;
        end
    end

    always_ff @(posedge clk) begin
        if (state == aguWalking && pwDone) begin
            outAddr   <= chkAddr;
            outExcept <= chkExc;
        end
        if (accept) begin
            addrQ      <= addr;
            outAddr    <= {2'b00, addr};  // Bare address, replaced after a walk
            outSize    <= size;
            outSignExt <= opcode == LB || opcode == LH;
            outExcept  <= earlyExc;
            outTag     <= tag;
            privQ      <= priv;
            sumQ       <= sum;
            mxrQ       <= mxr;
        end
    end

    noStrayDone: assert property (@(posedge clk) disable iff (rst)
        pwDone |-> state == aguWalking)
        else $error("loadAgu: walk completion without a pending request");

endmodule

// File: storeAgu.sv
module storeAgu (
    input  logic            clk,
    input  logic            rst,
    input  logic            inValid,
    input  lsuPkg::storeOpE opcode,
    input  lsuPkg::wordT    base,
    input  logic [11:0]     imm,
    input  lsuPkg::wordT    srcB,
    input  lsuPkg::wordT    srcC,
    input  lsuPkg::tagT     tag,
    input  logic            hold,
    input  logic            vmEnable,
    input  lsuPkg::privE    priv,
    input  logic            sum,
    input  logic            pwDone,
    input  lsuPkg::pteT     pwPte,
    input  logic            pwSuper,
    input  logic            pwFault,
    output logic            stall,
    output logic            outValid,
    output lsuPkg::paddrT   outAddr,
    output logic [1:0]      outSize,
    output lsuPkg::aguExcE  outExcept,
    output lsuPkg::tagT     outTag,
    output logic [3:0]      outWmask,
    output lsuPkg::wordT    outData,
    output logic            pwReq,
    output lsuPkg::vaddrT   pwVaddr
);
    import lsuPkg::*;

    aguStateE   state;
    logic       isAmo;
    vaddrT      addr;
    vaddrT      addrQ;
    logic [1:0] size;
    logic [3:0] wmask;
    wordT       data;
    aguExcE     earlyExc;
    logic       accept;
    privE       privQ;
    logic       sumQ;
    paddrT      chkAddr;
    aguExcE     chkExc;

    assign isAmo    = opcode >= AMOSWAP;
    assign addr     = isAmo ? base : base + {{20{imm[11]}}, imm};  // AMOs use rs1 alone
    assign stall    = (state == aguWalking) || (state == aguResult && hold);
    assign accept   = inValid && !stall;
    assign outValid = state == aguResult;
    assign pwReq    = state == aguWalking;
    assign pwVaddr  = addrQ;

    always_comb begin
        case (opcode)
            SB:      size = 2'd0;
            SH:      size = 2'd1;
            default: size = 2'd2;
        endcase

        if ((size == 2'd1 && addr[0]) || (size == 2'd2 && addr[1:0] != 2'b00))
            earlyExc = excMisalign;
        else if (!vmEnable && addr[$bits(vaddrT)-1:LEGAL_TOP] != '0)
            earlyExc = excAccessFault;
        else
            earlyExc = excNone;
    end

    // Lane placement and AMO result
    always_comb begin
        wmask = 4'b1111;
        data  = srcB;
        case (opcode)
            SB: begin
                wmask = 4'b0001 << addr[1:0];
                data  = srcB << {addr[1:0], 3'b000};
            end
            SH: begin
                wmask = addr[1] ? 4'b1100 : 4'b0011;
                data  = srcB << {addr[1], 4'b0000};
            end
            AMOADD:  data = srcB + srcC;
            AMOXOR:  data = srcB ^ srcC;
            AMOAND:  data = srcB & srcC;
            AMOOR:   data = srcB | srcC;
            AMOMIN:  data = ($signed(srcB) < $signed(srcC)) ? srcB : srcC;
            AMOMAX:  data = ($signed(srcB) < $signed(srcC)) ? srcC : srcB;
            AMOMINU: data = (srcB < srcC) ? srcB : srcC;
            AMOMAXU: data = (srcB < srcC) ? srcC : srcB;
            default: data = srcB;  // SW and AMOSWAP
        endcase
    end

    pteCheck #(.isStore(1'b1)) check (
        .pte      (pwPte),
        .isSuper  (pwSuper),
        .walkFault(pwFault),
        .vaddr    (addrQ),
        .priv     (privQ),
        .sum      (sumQ),
        .mxr      (1'b0),
        .paddr    (chkAddr),
        .except   (chkExc)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= aguIdle;
        end else begin
            if (state == aguResult && !hold)
                state <= aguIdle;
            if (state == aguWalking && pwDone)
                state <= aguResult;
            if (accept)
                state <= (vmEnable && earlyExc == excNone) ? aguWalking : aguResult;
        end
    end

    always_ff @(posedge clk) begin
        if (state == aguWalking && pwDone) begin
            outAddr   <= chkAddr;
            outExcept <= chkExc;
        end
        if (accept) begin
            addrQ     <= addr;
            outAddr   <= {2'b00, addr};
            outSize   <= size;
            outExcept <= earlyExc;
            outTag    <= tag;
            outWmask  <= wmask;
            outData   <= data;
            privQ     <= priv;
            sumQ      <= sum;
        end
    end

    // A clean store always writes at least one byte
    maskOnClean: assert property (@(posedge clk) disable iff (rst)
        outValid && outExcept == excNone |-> outWmask != 4'b0000)
        else $error("storeAgu: empty byte mask on a clean store");

endmodule

// File: pageWalker.sv
module pageWalker (
    input  logic          clk,
    input  logic          rst,
    input  lsuPkg::ppnT   rootPpn,
    input  logic          ldReq,
    input  lsuPkg::vaddrT ldVaddr,
    input  logic          stReq,
    input  lsuPkg::vaddrT stVaddr,
    input  lsuPkg::pteT   wbDatI,
    input  logic          wbAck,
    output logic          ldDone,
    output logic          stDone,
    output lsuPkg::pteT   pwPte,
    output logic          pwSuper,
    output logic          pwFault,
    output logic          wbCyc,
    output logic          wbStb,
    output lsuPkg::paddrT wbAdr
);
    import lsuPkg::*;

    walkStateE state;
    logic      owner;  // High while the store side owns the walk
    vaddrT     vaddrQ;
    vaddrT     reqVaddr;
    logic      invalid;
    logic      leaf;

    // Load side wins a tie
    assign reqVaddr = ldReq ? ldVaddr : stVaddr;

    // Decode of the entry on the bus
    assign invalid = !wbDatI[PTE_V] || (wbDatI[PTE_W] && !wbDatI[PTE_R]);
    assign leaf    = wbDatI[PTE_R] || wbDatI[PTE_X];

    assign ldDone = state == walkDone && !owner;
    assign stDone = state == walkDone && owner;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= walkIdle;
            wbCyc   <= 1'b0;
            wbStb   <= 1'b0;
            pwSuper <= 1'b0;
            pwFault <= 1'b0;
        end else begin
            case (state)
                walkIdle: begin
                    if (ldReq || stReq) begin
                        owner  <= !ldReq;
                        vaddrQ <= reqVaddr;
                        wbAdr  <= {rootPpn, reqVaddr[31:22], 2'b00};
                        wbCyc  <= 1'b1;
                        wbStb  <= 1'b1;
                        state  <= walkLevel1;
                    end
                end
                walkLevel1: begin
                    if (wbAck) begin
                        wbCyc <= 1'b0;
                        wbStb <= 1'b0;
                        pwPte <= wbDatI;
                        if (invalid || leaf) begin
                            pwSuper <= !invalid;
                            pwFault <= invalid;
                            state   <= walkDone;
                        end else begin
                            // Pointer to the level-0 table
                            wbAdr <= {wbDatI[31:10], vaddrQ[21:12], 2'b00};
                            state <= walkLevel0;
                        end
                    end
                end
                walkLevel0: begin
                    if (!wbCyc) begin
                        wbCyc <= 1'b1;  // Bus idled for a cycle after the first read
                        wbStb <= 1'b1;
                    end else if (wbAck) begin
                        wbCyc   <= 1'b0;
                        wbStb   <= 1'b0;
                        pwPte   <= wbDatI;
                        pwSuper <= 1'b0;
                        pwFault <= invalid || !leaf;
                        state   <= walkDone;
                    end
                end
                default: state <= walkIdle;  // walkDone lasts one cycle
            endcase
        end
    end

    stbInCyc: assert property (@(posedge clk) disable iff (rst) wbStb |-> wbCyc)
        else $error("pageWalker: strobe outside a cycle");

    holdUntilAck: assert property (@(posedge clk) disable iff (rst)
        wbStb && !wbAck |=> wbStb && $stable(wbAdr))
        else $error("pageWalker: read dropped or moved before ack");

endmodule

// File: memStage.sv
module memStage (
    input  logic            clk,
    input  logic            rst,
    input  logic            vmEnable,
    input  lsuPkg::ppnT     rootPpn,
    input  lsuPkg::privE    priv,
    input  logic            sum,
    input  logic            mxr,
    input  logic            ldInValid,
    input  lsuPkg::loadOpE  ldOpcode,
    input  lsuPkg::wordT    ldBase,
    input  logic [11:0]     ldImm,
    input  lsuPkg::tagT     ldTag,
    input  logic            ldHold,
    output logic            ldStall,
    output logic            ldOutValid,
    output lsuPkg::paddrT   ldOutAddr,
    output logic [1:0]      ldOutSize,
    output logic            ldOutSignExt,
    output lsuPkg::aguExcE  ldOutExcept,
    output lsuPkg::tagT     ldOutTag,
    input  logic            stInValid,
    input  lsuPkg::storeOpE stOpcode,
    input  lsuPkg::wordT    stBase,
    input  logic [11:0]     stImm,
    input  lsuPkg::wordT    stSrcB,
    input  lsuPkg::wordT    stSrcC,
    input  lsuPkg::tagT     stTag,
    input  logic            stHold,
    output logic            stStall,
    output logic            stOutValid,
    output lsuPkg::paddrT   stOutAddr,
    output logic [1:0]      stOutSize,
    output lsuPkg::aguExcE  stOutExcept,
    output lsuPkg::tagT     stOutTag,
    output logic [3:0]      stOutWmask,
    output lsuPkg::wordT    stOutData,
    output logic            wbCyc,
    output logic            wbStb,
    output lsuPkg::paddrT   wbAdr,
    input  lsuPkg::pteT     wbDatI,
    input  logic            wbAck
);
    import lsuPkg::*;

    logic  ldPwReq;
    vaddrT ldPwVaddr;
    logic  ldPwDone;
    logic  stPwReq;
    vaddrT stPwVaddr;
    logic  stPwDone;
    pteT   pwPte;  // Walk result shared by both sides
    logic  pwSuper;
    logic  pwFault;

    loadAgu loadAgu_inst (
        .clk       (clk),
        .rst       (rst),
        .inValid   (ldInValid),
        .opcode    (ldOpcode),
        .base      (ldBase),
        .imm       (ldImm),
        .tag       (ldTag),
        .hold      (ldHold),
        .vmEnable  (vmEnable),
        .priv      (priv),
        .sum       (sum),
        .mxr       (mxr),
        .pwDone    (ldPwDone),
        .pwPte     (pwPte),
        .pwSuper   (pwSuper),
        .pwFault   (pwFault),
        .stall     (ldStall),
        .outValid  (ldOutValid),
        .outAddr   (ldOutAddr),
        .outSize   (ldOutSize),
        .outSignExt(ldOutSignExt),
        .outExcept (ldOutExcept),
        .outTag    (ldOutTag),
        .pwReq     (ldPwReq),
        .pwVaddr   (ldPwVaddr)
    );

    storeAgu storeAgu_inst (
        .clk      (clk),
        .rst      (rst),
        .inValid  (stInValid),
        .opcode   (stOpcode),
        .base     (stBase),
        .imm      (stImm),
        .srcB     (stSrcB),
        .srcC     (stSrcC),
        .tag      (stTag),
        .hold     (stHold),
        .vmEnable (vmEnable),
        .priv     (priv),
        .sum      (sum),
        .pwDone   (stPwDone),
        .pwPte    (pwPte),
        .pwSuper  (pwSuper),
        .pwFault  (pwFault),
        .stall    (stStall),
        .outValid (stOutValid),
        .outAddr  (stOutAddr),
        .outSize  (stOutSize),
        .outExcept(stOutExcept),
        .outTag   (stOutTag),
        .outWmask (stOutWmask),
        .outData  (stOutData),
        .pwReq    (stPwReq),
        .pwVaddr  (stPwVaddr)
    );

    pageWalker pageWalker_inst (
        .clk    (clk),
        .rst    (rst),
        .rootPpn(rootPpn),
        .ldReq  (ldPwReq),
        .ldVaddr(ldPwVaddr),
        .stReq  (stPwReq),
        .stVaddr(stPwVaddr),
        .wbDatI (wbDatI),
        .wbAck  (wbAck),
        .ldDone (ldPwDone),
        .stDone (stPwDone),
        .pwPte  (pwPte),
        .pwSuper(pwSuper),
        .pwFault(pwFault),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbAdr  (wbAdr)
    );

endmodule

// File: tbClock.sv
module tbClock (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial clk = 1'b0;
    always #20 clk = ~clk;

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #2 rst = 1'b0;
    end

endmodule

// File: tbChecker.sv
module tbChecker (
    input logic            clk,
    input logic            rst,
    input logic            vmEnable,
    input lsuPkg::ppnT     rootPpn,
    input lsuPkg::privE    priv,
    input logic            sum,
    input logic            mxr,
    input logic            ldInValid,
    input logic            ldStall,
    input lsuPkg::loadOpE  ldOpcode,
    input lsuPkg::wordT    ldBase,
    input logic [11:0]     ldImm,
    input lsuPkg::tagT     ldTag,
    input logic            ldHold,
    input logic            ldOutValid,
    input lsuPkg::paddrT   ldOutAddr,
    input logic [1:0]      ldOutSize,
    input logic            ldOutSignExt,
    input lsuPkg::aguExcE  ldOutExcept,
    input lsuPkg::tagT     ldOutTag,
    input logic            stInValid,
    input logic            stStall,
    input lsuPkg::storeOpE stOpcode,
    input lsuPkg::wordT    stBase,
    input logic [11:0]     stImm,
    input lsuPkg::wordT    stSrcB,
    input lsuPkg::wordT    stSrcC,
    input lsuPkg::tagT     stTag,
    input logic            stHold,
    input logic            stOutValid,
    input lsuPkg::paddrT   stOutAddr,
    input logic [1:0]      stOutSize,
    input lsuPkg::aguExcE  stOutExcept,
    input lsuPkg::tagT     stOutTag,
    input logic [3:0]      stOutWmask,
    input lsuPkg::wordT    stOutData,
    input logic            wbCyc,
    input logic            wbStb
);
    timeunit 1ns;
    timeprecision 100ps;
    import lsuPkg::*;

    localparam ppnT LEAF_MASK = 22'h05A5A;  // Leaf PPN scramble

    typedef struct packed {
        paddrT      addr;
        logic [1:0] size;
        logic       signExt;
        aguExcE     exc;
        tagT        tag;
        logic [3:0] wmask;
        wordT       data;
    } resultT;

    resultT ldQ[$];
    resultT stQ[$];
    string  testName = "none";
    int     testErrors;
    int     testResults;
    int     errors;
    int     testsPassed;
    int     testsFailed;

    // Flags byte {D, A, G, U, X, W, R, V} taken from the low VPN bits
    function automatic logic [7:0] flagsFor(input logic [9:0] vpn);
        return {vpn[5], vpn[4], 1'b0, vpn[3], vpn[2], vpn[1], vpn[0], 1'b1};
    endfunction

    function automatic pteT pageTableRead(input paddrT a);
        logic [9:0] vpn1;
        logic [9:0] vpn0;
        ppnT        tbl;
        tbl = a[33:12];
        if (tbl == 22'h10) begin
            vpn1 = a[11:2];
            case (vpn1[1:0])
                2'd0: return {22'h20 + {12'b0, vpn1}, 10'h001};  // Pointer
                2'd1: return {{2'b0, vpn1} ^ LEAF_MASK[21:10], 10'h000, 2'b00, flagsFor(vpn1)};
                2'd2: return '0;
                default: return {{2'b0, vpn1} ^ LEAF_MASK[21:10], 10'h001, 2'b00, flagsFor(vpn1)};
            endcase
        end
        vpn1 = tbl[9:0] - 10'h20;
        vpn0 = a[11:2];
        return {{2'b0, vpn1, vpn0} ^ LEAF_MASK, 2'b00, flagsFor(vpn0)};
    endfunction

    function automatic resultT expectResult(input bit isStore, input logic [3:0] op,
            input wordT base, input logic [11:0] imm, input wordT srcB, input wordT srcC,
            input tagT tag, input logic vm, input ppnT root, input privE pv,
            input logic sm, input logic mx);
        resultT r;
        vaddrT  va;
        pteT    pte;
        ppnT    ppn;
        logic   isSuper;
        logic   fault;
        logic   canAccess;
        logic   badPerm;
        r = '0;
        r.tag = tag;
        va = (isStore && op >= AMOSWAP) ? base : base + {{20{imm[11]}}, imm};
        if (isStore) begin
            r.size  = (op == SB) ? 2'd0 : (op == SH) ? 2'd1 : 2'd2;
            r.wmask = 4'b1111;
            r.data  = srcB;
            case (op)
                SB: begin
                    r.wmask = 4'b0001 << va[1:0];
                    r.data  = srcB << (8 * va[1:0]);
                end
                SH: begin
                    r.wmask = va[1] ? 4'b1100 : 4'b0011;
                    r.data  = va[1] ? {srcB[15:0], 16'h0} : srcB;
                end
                AMOADD:  r.data = srcB + srcC;
                AMOXOR:  r.data = srcB ^ srcC;
                AMOAND:  r.data = srcB & srcC;
                AMOOR:   r.data = srcB | srcC;
                AMOMIN:  r.data = ($signed(srcB) <= $signed(srcC)) ? srcB : srcC;
                AMOMAX:  r.data = ($signed(srcB) >= $signed(srcC)) ? srcB : srcC;
                AMOMINU: r.data = (srcB <= srcC) ? srcB : srcC;
                AMOMAXU: r.data = (srcB >= srcC) ? srcB : srcC;
                default: r.data = srcB;
            endcase
        end else begin
            r.size    = (op == LB || op == LBU) ? 2'd0 : (op == LH || op == LHU) ? 2'd1 : 2'd2;
            r.signExt = op == LB || op == LH;
        end
        r.addr = {2'b00, va};
        if ((r.size == 2'd1 && va[0]) || (r.size == 2'd2 && va[1:0] != 2'b00)) begin
            r.exc = excMisalign;
            return r;
        end
        if (!vm) begin
            r.exc = va[31] ? excAccessFault : excNone;
            return r;
        end
        // Two-level walk over the page-table rule
        pte = pageTableRead({root, va[31:22], 2'b00});
        isSuper = 1'b0;
        fault   = 1'b0;
        if (!pte[PTE_V] || (pte[PTE_W] && !pte[PTE_R]))
            fault = 1'b1;
        else if (pte[PTE_R] || pte[PTE_X])
            isSuper = 1'b1;
        else begin
            pte = pageTableRead({pte[31:10], va[21:12], 2'b00});
            fault = !pte[PTE_V] || (pte[PTE_W] && !pte[PTE_R]) || !(pte[PTE_R] || pte[PTE_X]);
        end
        ppn = pte[31:10];
        r.addr = isSuper ? {ppn[21:10], va[21:0]} : {ppn, va[11:0]};
        canAccess = isStore ? pte[PTE_R] && pte[PTE_W] : pte[PTE_R] || (mx && pte[PTE_X]);
        badPerm = fault || !canAccess || !pte[PTE_A] || (isStore && !pte[PTE_D])
               || (pv == privUser && !pte[PTE_U])
               || (pv == privSuper && pte[PTE_U] && !sm)
               || (isSuper && ppn[9:0] != 10'h0);
        if (r.addr[33:31] != 3'b000)
            r.exc = excAccessFault;
        else
            r.exc = badPerm ? excPageFault : excNone;
        return r;
    endfunction

    function automatic int pending();
        return ldQ.size() + stQ.size();
    endfunction

    task automatic startTest(input string name);
        testName    = name;
        testErrors  = 0;
        testResults = 0;
    endtask

    task automatic endTest();
        if (testErrors == 0)
            testsPassed++;
        else
            testsFailed++;
        $display("test %s: %0d results, %0d errors", testName, testResults, testErrors);
    endtask

    task automatic compareResult(input string side, input resultT act, inout resultT q[$]);
        resultT exp;
        testResults++;
        if (q.size() == 0) begin
            $display("%s side gave a result with no operation outstanding in %s", side, testName);
            testErrors++;
            errors++;
        end else begin
            exp = q.pop_front();
            if (act !== exp) begin
                $display("mismatch %s %s expected %h actual %h", testName, side, exp, act);
                testErrors++;
                errors++;
            end
        end
    endtask

    // One operation in flight per side, so an outstanding one without a result is walking
    task automatic checkStall(input string side, input logic resValid, input logic hold,
            input int outstanding, input logic stall);
        logic exp;
        exp = resValid ? hold : (outstanding != 0);
        if (stall !== exp) begin
            $display("mismatch %s %s stall expected %b actual %b", testName, side, exp, stall);
            testErrors++;
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            checkStall("load", ldOutValid, ldHold, ldQ.size(), ldStall);
            checkStall("store", stOutValid, stHold, stQ.size(), stStall);
            if (wbCyc !== wbStb) begin
                $display("Wishbone cycle and strobe disagree in %s", testName);
                testErrors++;
                errors++;
            end
            if (ldInValid && !ldStall)
                ldQ.push_back(expectResult(1'b0, {1'b0, ldOpcode}, ldBase, ldImm, '0, '0,
                    ldTag, vmEnable, rootPpn, priv, sum, mxr));
            if (stInValid && !stStall)
                stQ.push_back(expectResult(1'b1, stOpcode, stBase, stImm, stSrcB, stSrcC,
                    stTag, vmEnable, rootPpn, priv, sum, 1'b0));
            if (ldOutValid && !ldHold)
                compareResult("load", {ldOutAddr, ldOutSize, ldOutSignExt, ldOutExcept,
                    ldOutTag, 4'b0000, 32'h0}, ldQ);
            if (stOutValid && !stHold)
                compareResult("store", {stOutAddr, stOutSize, 1'b0, stOutExcept,
                    stOutTag, stOutWmask, stOutData}, stQ);
        end
    end

endmodule

// File: tbTop.sv
module tbTop;
    timeunit 1ns;
    timeprecision 100ps;
    import lsuPkg::*;

    localparam int TOTAL_OPS = 260;

    logic     clk;
    logic     rst;
    logic     vmEnable = 1'b0;
    ppnT      rootPpn = 22'h10;
    privE     priv = privSuper;
    logic     sum = 1'b1;
    logic     mxr = 1'b0;
    logic     ldInValid = 1'b0;
    loadOpE   ldOpcode = LW;
    wordT     ldBase = '0;
    logic [11:0] ldImm = '0;
    tagT      ldTag = '0;
    logic     ldHold = 1'b0;
    logic     ldStall;
    logic     ldOutValid;
    paddrT    ldOutAddr;
    logic [1:0] ldOutSize;
    logic     ldOutSignExt;
    aguExcE   ldOutExcept;
    tagT      ldOutTag;
    logic     stInValid = 1'b0;
    storeOpE  stOpcode = SW;
    wordT     stBase = '0;
    logic [11:0] stImm = '0;
    wordT     stSrcB = '0;
    wordT     stSrcC = '0;
    tagT      stTag = '0;
    logic     stHold = 1'b0;
    logic     stStall;
    logic     stOutValid;
    paddrT    stOutAddr;
    logic [1:0] stOutSize;
    aguExcE   stOutExcept;
    tagT      stOutTag;
    logic [3:0] stOutWmask;
    wordT     stOutData;
    logic     wbCyc;
    logic     wbStb;
    paddrT    wbAdr;
    pteT      wbDatI = '0;
    logic     wbAck = 1'b0;
    logic [31:0] lfsr = 32'd90163;
    logic     stress = 1'b0;  // Random hold and ack delay
    int       waitLeft = 0;

    tbClock clockGen (.clk(clk), .rst(rst));
    memStage memStage_inst (.*);
    tbChecker checker_inst (.*);

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    always begin
        @(posedge clk);
        #2;
        ldHold = stress && randBits(2) == 2'd3;
        stHold = stress && randBits(2) == 2'd3;
    end

    // Page-table memory on the Wishbone read port
    always begin
        @(posedge clk);
        #2;
        if (wbStb && !wbAck) begin
            if (waitLeft == 0) begin
                wbAck  = 1'b1;
                wbDatI = checker_inst.pageTableRead(wbAdr);
            end else begin
                waitLeft--;
            end
        end else begin
            wbAck    = 1'b0;
            waitLeft = stress ? int'(randBits(2)) : 0;
        end
    end

    task automatic randomMode();
        priv = privE'(randBits(1));
        sum  = randBits(1);
        mxr  = randBits(1);
    endtask

    task automatic driveLoads(input int n, input bit aligned, input bit randMd);
        bit busy;
        for (int i = 0; i < n; i++) begin
            ldOpcode = loadOpE'(randBits(3) % 5);
            ldBase   = randBits(32);
            ldImm    = randBits(12);
            if (aligned) begin
                ldBase[1:0] = 2'b00;
                ldImm[1:0]  = 2'b00;
            end
            ldTag = ldTag + 1;
            if (randMd)
                randomMode();
            ldInValid = 1'b1;
            do begin
                @(negedge clk);
                busy = ldStall;  // Settled after this cycle's hold update
                @(posedge clk);
                #2;
            end while (busy);
            ldInValid = 1'b0;
        end
    endtask

    task automatic driveStores(input int n, input bit aligned, input bit randMd);
        bit busy;
        for (int i = 0; i < n; i++) begin
            stOpcode = storeOpE'(randBits(4) % 12);
            stBase   = randBits(32);
            stImm    = randBits(12);
            stSrcB   = randBits(32);
            stSrcC   = randBits(32);
            if (aligned) begin
                stBase[1:0] = 2'b00;
                stImm[1:0]  = 2'b00;
            end
            stTag = stTag + 1;
            if (randMd)
                randomMode();
            stInValid = 1'b1;
            do begin
                @(negedge clk);
                busy = stStall;
                @(posedge clk);
                #2;
            end while (busy);
            stInValid = 1'b0;
        end
    endtask

    task automatic runTest(input string name, input int nLd, input int nSt, input bit vm,
            input bit randMd, input bit stressOn);
        checker_inst.startTest(name);
        vmEnable = vm;
        stress   = stressOn;
        priv     = privSuper;
        sum      = 1'b1;
        mxr      = 1'b0;
        fork
            driveLoads(nLd, vm, randMd);
            driveStores(nSt, vm, randMd);
        join
        while (checker_inst.pending() != 0) begin
            @(posedge clk);
            #2;
        end
        stress = 1'b0;
        checker_inst.endTest();
    endtask

    initial begin
        #(TOTAL_OPS * 400 * 40 + 8000);
        $display("Timeout: results stopped arriving before all operations completed");
        $display("Test failures found");
        $finish;
    end

    initial begin
        @(negedge rst);
        @(posedge clk);
        #2;
        runTest("bareLoad", 40, 0, 1'b0, 1'b0, 1'b0);
        runTest("bareStore", 0, 40, 1'b0, 1'b0, 1'b0);
        runTest("sv32Translate", 25, 25, 1'b1, 1'b0, 1'b0);
        runTest("sv32Faults", 25, 25, 1'b1, 1'b1, 1'b0);
        runTest("concurrency", 40, 40, 1'b1, 1'b1, 1'b1);
        $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
            checker_inst.testsPassed, checker_inst.testsFailed, checker_inst.errors);
        if (checker_inst.errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// File: memStage.f
lsuPkg.sv
pteCheck.sv
loadAgu.sv
storeAgu.sv
pageWalker.sv
memStage.sv
tbClock.sv
tbChecker.sv
tbTop.sv
